// File: all.f
src/mcu_periph_pkg.sv
src/mcu_gpio.sv
src/mcu_timer.sv
src/mcu_uart_tx.sv
src/mcu_interrupt_ctrl.sv
src/mcu_peripherals.sv
sim/tb_clock_gen.sv
sim/tb_mcu_peripherals.sv

// File: sim/tb_mcu_peripherals.sv
// ================================================
// directed tests for the peripheral block: bus
// helpers, per-test checks and the final report
// ================================================
`timescale 1ns/100ps

module tb_mcu_peripherals;

    localparam int base_addr  = 'hFF00;
    localparam int intc_base  = mcu_periph_pkg::intc_off;
    localparam int gpio_base  = mcu_periph_pkg::gpio_off;
    localparam int timer_base = mcu_periph_pkg::timer_off;
    localparam int uart_base  = mcu_periph_pkg::uart_off;

    localparam logic [2:0] gpio_bit  = 3'b001 << mcu_periph_pkg::gpio;
    localparam logic [2:0] timer_bit = 3'b001 << mcu_periph_pkg::timer;
    localparam logic [2:0] uart_bit  = 3'b001 << mcu_periph_pkg::uart;

    logic        clk;
    logic        rst_n;
    logic        enable;
    logic        write_en;
    logic [15:0] addr;
    logic [7:0]  data_in;
    logic [7:0]  data_out;
    logic [15:0] gpi;
    logic [15:0] gpo;
    logic        tx;
    logic [2:0]  interrupt_request;

    int cyc = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;

    tb_clock_gen clock_gen (.clk(clk), .rst_n(rst_n));

    mcu_peripherals #(.addr_width(16), .base_addr(16'hFF00), .default_divider(103)) dut (
        .clk(clk), .rst_n(rst_n), .enable(enable), .write_en(write_en), .addr(addr),
        .data_in(data_in), .data_out(data_out), .gpi(gpi), .gpo(gpo), .tx(tx),
        .interrupt_request(interrupt_request));

    // cycle count, used to place the uart mid-bit samples
    always @(posedge clk)
        cyc <= cyc + 1;

    task automatic report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic stop_on_timeout(input string why);
        $display("ERROR at %0t: %s, run stopped", $time, why);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
            $display("test %s: ok", name);
        else
        begin
            tests_failed++;
            $display("test %s: %0d failing checks", name, errors - err_before);
        end
    endtask

    task automatic bus_write(input int off, input logic [7:0] d);
        @(posedge clk);
        #2;
        enable   = 1'b1;
        write_en = 1'b1;
        addr     = 16'(base_addr + off);
        data_in  = d;
        @(posedge clk);
        #2;
        enable   = 1'b0;
        write_en = 1'b0;
    endtask

    // read data is combinational, sampled 1 ns after driving
    task automatic bus_read(input int off, output logic [7:0] d);
        @(posedge clk);
        #2;
        enable   = 1'b1;
        write_en = 1'b0;
        addr     = 16'(base_addr + off);
        #1;
        d        = data_out;
        enable   = 1'b0;
    endtask

    task automatic wait_cycle(input int target);
        int n;
        n = 0;
        while (cyc < target && n < 1000)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (cyc < target)
            stop_on_timeout("clock cycle count not reached");
    endtask

    task automatic poll_bit(input int off, input int b, input logic val, input int limit,
                            input string what);
        logic [7:0] rd;
        int n;
        n = 0;
        bus_read(off, rd);
        while (rd[b] !== val && n < limit)
        begin
            bus_read(off, rd);
            n++;
        end
        if (rd[b] !== val)
            stop_on_timeout({"timed out waiting for ", what});
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1 && n < 100)
        begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1)
            stop_on_timeout("reset was never released");
    endtask

    task automatic test_reset();
        int err0;
        logic [7:0] rd;
        err0 = errors;
        bus_read(0, rd);
        if (rd !== 8'hA5)
            report_mismatch($sformatf("id byte read %h", rd));
        if (tx !== 1'b1 || gpo !== 16'h0000 || interrupt_request !== 3'b000)
            report_mismatch($sformatf("after reset tx %b gpo %h irq %b",
                                      tx, gpo, interrupt_request));
        bus_read(-1, rd);
        if (rd !== 8'h00)
            report_mismatch($sformatf("address below window read %h", rd));
        bus_read(14, rd);
        if (rd !== 8'h00)
            report_mismatch($sformatf("address above window read %h", rd));
        bus_read(uart_base + 2, rd);
        if (rd !== 8'd103)
            report_mismatch($sformatf("divider low byte after reset %h", rd));
        // write cycle with enable low
        @(posedge clk);
        #2;
        write_en = 1'b1;
        addr     = 16'(base_addr + gpio_base + 2);
        data_in  = 8'h5A;
        @(posedge clk);
        #2;
        write_en = 1'b0;
        if (gpo !== 16'h0000)
            report_mismatch($sformatf("write with enable low changed gpo to %h", gpo));
        close_test("reset", err0);
    endtask

    task automatic test_gpio();
        int err0;
        logic [7:0] rd;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [15:0] pat;
        err0 = errors;
        lo = 8'($urandom);
        hi = 8'($urandom);
        bus_write(gpio_base + 2, lo);
        bus_write(gpio_base + 3, hi);
        if (gpo !== {hi, lo})
            report_mismatch($sformatf("gpo %h, expected %h", gpo, {hi, lo}));
        bus_read(gpio_base + 2, rd);
        if (rd !== lo)
            report_mismatch($sformatf("gpo low readback %h, expected %h", rd, lo));
        bus_read(gpio_base + 3, rd);
        if (rd !== hi)
            report_mismatch($sformatf("gpo high readback %h, expected %h", rd, hi));
        pat = 16'($urandom);
        @(posedge clk);
        #2 gpi = pat;
        wait_cycle(cyc + 2);
        bus_read(gpio_base, rd);
        if (rd !== pat[7:0])
            report_mismatch($sformatf("gpi low read %h, expected %h", rd, pat[7:0]));
        bus_read(gpio_base + 1, rd);
        if (rd !== pat[15:8])
            report_mismatch($sformatf("gpi high read %h, expected %h", rd, pat[15:8]));
        close_test("gpio", err0);
    endtask

    task automatic test_timer();
        int err0;
        int seen;
        logic [7:0] rd;
        err0 = errors;
        seen = 0;
        bus_write(timer_base, 8'd1);
        bus_write(timer_base + 1, 8'd3);
        bus_write(timer_base + 2, 8'h01);
        poll_bit(timer_base + 2, 1, 1'b1, 100, "the timer wrapped flag");
        // stop and clear wrapped together
        bus_write(timer_base + 2, 8'h02);
        bus_read(timer_base + 2, rd);
        if (rd !== 8'h00)
            report_mismatch($sformatf("timer control after clear %h", rd));
        for (int n = 0; n < 200; n++)
        begin
            bus_read(timer_base + 2, rd);
            if (rd[1])
                seen++;
        end
        if (seen != 0)
            report_mismatch("wrap seen while run was clear");
        close_test("timer", err0);
    endtask

    task automatic test_uart();
        int err0;
        int fall_cyc;
        int low_cycles;
        logic [7:0] b;
        logic [7:0] rd;
        logic exp_bit;
        err0 = errors;
        low_cycles = 0;
        b = 8'($urandom);
        bus_write(uart_base + 2, 8'd7);
        bus_write(uart_base + 3, 8'd0);
        bus_write(uart_base, b);
        fall_cyc = cyc;
        if (tx !== 1'b0)
            report_mismatch("tx did not fall at the edge taking the data");
        // dropped while busy
        bus_write(uart_base, ~b);
        bus_read(uart_base + 1, rd);
        if (rd !== 8'h01)
            report_mismatch($sformatf("uart status during frame %h", rd));
        for (int k = 0; k < 10; k++)
        begin
            wait_cycle(fall_cyc + 4 + 8 * k);
            exp_bit = (k == 0) ? 1'b0 : (k == 9) ? 1'b1 : b[k - 1];
            if (tx !== exp_bit)
                report_mismatch($sformatf("frame bit %0d is %b, expected %b", k, tx, exp_bit));
        end
        for (int n = 0; n < 100; n++)
        begin
            @(posedge clk);
            #1;
            if (tx !== 1'b1)
                low_cycles++;
        end
        if (low_cycles != 0)
            report_mismatch("a second frame followed the first");
        poll_bit(uart_base + 1, 0, 1'b0, 100, "uart busy to drop");
        bus_read(uart_base, rd);
        if (rd !== b)
            report_mismatch($sformatf("uart data reg %h, expected %h", rd, b));
        close_test("uart", err0);
    endtask

    task automatic check_pending(input logic [2:0] exp, input logic [2:0] mask);
        logic [7:0] rd;
        bus_read(intc_base + 1, rd);
        if (rd !== {5'b0, exp})
            report_mismatch($sformatf("pending %b, expected %b", rd[2:0], exp));
        if (interrupt_request !== (exp & mask))
            report_mismatch($sformatf("interrupt_request %b, expected %b",
                                      interrupt_request, exp & mask));
    endtask

    task automatic test_interrupts();
        int err0;
        err0 = errors;
        bus_write(intc_base, 8'h07);
        bus_write(intc_base + 1, 8'h07);
        check_pending(3'b000, 3'b111);
        @(posedge clk);
        #2 gpi = gpi ^ (16'($urandom) | 16'h0001);
        poll_bit(intc_base + 1, mcu_periph_pkg::gpio, 1'b1, 20, "gpio pending bit");
        check_pending(gpio_bit, 3'b111);
        bus_write(timer_base + 2, 8'h01);
        poll_bit(intc_base + 1, mcu_periph_pkg::timer, 1'b1, 100, "timer pending bit");
        bus_write(timer_base + 2, 8'h02);
        check_pending(gpio_bit | timer_bit, 3'b111);
        bus_write(uart_base, 8'($urandom));
        poll_bit(intc_base + 1, mcu_periph_pkg::uart, 1'b1, 200, "uart pending bit");
        check_pending(3'b111, 3'b111);
        bus_write(intc_base, 8'h00);
        check_pending(3'b111, 3'b000);
        bus_write(intc_base, 8'h07);
        check_pending(3'b111, 3'b111);
        bus_write(intc_base + 1, 8'h07);
        check_pending(3'b000, 3'b111);
        close_test("interrupts", err0);
    endtask

    initial
    begin
        enable   = 1'b0;
        write_en = 1'b0;
        addr     = '0;
        data_in  = '0;
        gpi      = '0;
        void'($urandom(14));
        wait_reset();
        test_reset();
        test_gpio();
        test_timer();
        test_uart();
        test_interrupts();
        $display("%0d tests run, %0d failed, %0d failing checks",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: sim/tb_clock_gen.sv
// ================================================
// testbench clock and reset generator
// ================================================
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 10 cycles, released just after an edge
    initial
    begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

// File: src/mcu_peripherals.sv
// ================================================
// peripheral block top level: window decode,
// id register and read-data merge
// ================================================
`timescale 1ns/100ps

module mcu_peripherals #(
    parameter int                    addr_width      = 16,
    parameter logic [addr_width-1:0] base_addr       = 16'hFF00,
    parameter int                    default_divider = 103
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  enable,
    input  logic                  write_en,
    input  logic [addr_width-1:0] addr,
    input  logic [7:0]            data_in,
    output logic [7:0]            data_out,
    input  logic [15:0]           gpi,
    output logic [15:0]           gpo,
    output logic                  tx,
    output logic [2:0]            interrupt_request
);

    localparam int ow = mcu_periph_pkg::offset_width;

    logic [addr_width-1:0] rel;
    logic [ow-1:0] offset;
    logic [ow-1:0] idx_intc, idx_gpio, idx_timer, idx_uart;
    logic in_window;
    logic sel_hwi, sel_intc, sel_gpio, sel_timer, sel_uart;
    logic [7:0] dout_hwi, dout_intc, dout_gpio, dout_timer, dout_uart;
    logic gpio_irq, timer_irq, uart_irq;

    function automatic logic hit(input logic [ow-1:0] off, input logic [ow-1:0] base,
                                 input logic [ow-1:0] size);
        return (off >= base) && (off < base + size);
    endfunction

    assign rel       = addr - base_addr;
    assign offset    = rel[ow-1:0];
    assign in_window = enable && (addr >= base_addr) && (rel < mcu_periph_pkg::total_size);

    assign sel_hwi   = in_window && hit(offset, mcu_periph_pkg::hwi_off, mcu_periph_pkg::hwi_size);
    assign sel_intc  = in_window && hit(offset, mcu_periph_pkg::intc_off, mcu_periph_pkg::intc_size);
    assign sel_gpio  = in_window && hit(offset, mcu_periph_pkg::gpio_off, mcu_periph_pkg::gpio_size);
    assign sel_timer = in_window &&
                       hit(offset, mcu_periph_pkg::timer_off, mcu_periph_pkg::timer_size);
    assign sel_uart  = in_window && hit(offset, mcu_periph_pkg::uart_off, mcu_periph_pkg::uart_size);

    // unit-local register index
    assign idx_intc  = offset - mcu_periph_pkg::intc_off;
    assign idx_gpio  = offset - mcu_periph_pkg::gpio_off;
    assign idx_timer = offset - mcu_periph_pkg::timer_off;
    assign idx_uart  = offset - mcu_periph_pkg::uart_off;

    assign dout_hwi = sel_hwi ? mcu_periph_pkg::hw_id : 8'h00;

    mcu_interrupt_ctrl intc (
        .clk(clk), .rst_n(rst_n), .sel(sel_intc), .write_en(write_en),
        .reg_idx(idx_intc[0]), .data_in(data_in), .data_out(dout_intc),
        .gpio_irq(gpio_irq), .timer_irq(timer_irq), .uart_irq(uart_irq),
        .interrupt_request(interrupt_request));

    mcu_gpio gpio (
        .clk(clk), .rst_n(rst_n), .sel(sel_gpio), .write_en(write_en),
        .reg_idx(idx_gpio[1:0]), .data_in(data_in), .data_out(dout_gpio),
        .gpi(gpi), .gpo(gpo), .gpio_irq(gpio_irq));

    mcu_timer timer (
        .clk(clk), .rst_n(rst_n), .sel(sel_timer), .write_en(write_en),
        .reg_idx(idx_timer[1:0]), .data_in(data_in), .data_out(dout_timer),
        .timer_irq(timer_irq));

    mcu_uart_tx #(.default_divider(default_divider)) uart (
        .clk(clk), .rst_n(rst_n), .sel(sel_uart), .write_en(write_en),
        .reg_idx(idx_uart[1:0]), .data_in(data_in), .data_out(dout_uart),
        .tx(tx), .uart_irq(uart_irq));

    // unselected units drive zero
    assign data_out = dout_hwi | dout_intc | dout_gpio | dout_timer | dout_uart;

endmodule

// File: src/mcu_interrupt_ctrl.sv
// ================================================
// interrupt controller, pending and mask registers
// ================================================
`timescale 1ns/100ps

module mcu_interrupt_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sel,
    input  logic       write_en,
    input  logic       reg_idx,
    input  logic [7:0] data_in,
    output logic [7:0] data_out,
    input  logic       gpio_irq,
    input  logic       timer_irq,
    input  logic       uart_irq,
    output logic [2:0] interrupt_request
);

    logic [2:0] mask;
    logic [2:0] pending;
    logic [2:0] src;
    logic [2:0] clear;

    always_comb
    begin
        src = '0;
        src[mcu_periph_pkg::gpio]  = gpio_irq;
        src[mcu_periph_pkg::timer] = timer_irq;
        src[mcu_periph_pkg::uart]  = uart_irq;
    end

    // write 1 to clear
    assign clear = (sel && write_en && reg_idx) ? data_in[2:0] : 3'b0;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mask    <= '0;
            pending <= '0;
        end
        else
        begin
            if (sel && write_en && !reg_idx)
                mask <= data_in[2:0];
            // a new pulse wins over a clear
            pending <= (pending & ~clear) | src;
        end
    end

    assign interrupt_request = pending & mask;

    assign data_out = !sel   ? 8'h00 :
                      reg_idx ? {5'b0, pending} : {5'b0, mask};

    // bits cleared by a mask write stay off in the request vector
    a_masked_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        sel && write_en && !reg_idx |=>
            (interrupt_request & ~$past(data_in[2:0])) == 3'b000);

endmodule

// File: src/mcu_uart_tx.sv
// ================================================
// uart transmitter fsm with programmable divider
// and busy status
// ================================================
`timescale 1ns/100ps

module mcu_uart_tx #(
    parameter int default_divider = 103
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sel,
    input  logic       write_en,
    input  logic [1:0] reg_idx,
    input  logic [7:0] data_in,
    output logic [7:0] data_out,
    output logic       tx,
    output logic       uart_irq
);

    mcu_periph_pkg::uart_state_t state;

    logic [15:0] divider;
    logic [15:0] bit_cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  tx_data;
    logic [7:0]  shift;
    logic        busy;
    logic        accept;
    logic        bit_end;

    assign busy    = (state != mcu_periph_pkg::idle);
    // data written while busy is dropped
    assign accept  = sel && write_en && (reg_idx == 2'd0) && !busy;
    assign bit_end = (bit_cnt == 16'd0);

    // frame data and shift register
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            tx_data <= data_in;
            shift   <= data_in;
        end
        else if (busy && bit_end && state != mcu_periph_pkg::stop)
            shift <= shift >> 1;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= mcu_periph_pkg::idle;
            divider  <= 16'(default_divider);
            bit_cnt  <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            uart_irq <= 1'b0;
        end
        else
        begin
            uart_irq <= 1'b0;
            if (sel && write_en && reg_idx == 2'd2)
                divider[7:0] <= data_in;
            if (sel && write_en && reg_idx == 2'd3)
                divider[15:8] <= data_in;

            case (state)
                mcu_periph_pkg::idle:
                begin
                    tx <= 1'b1;
                    if (accept)
                    begin
                        state   <= mcu_periph_pkg::start;
                        tx      <= 1'b0;
                        bit_cnt <= divider;
                    end
                end
                mcu_periph_pkg::start:
                begin
                    bit_cnt <= bit_cnt - 16'd1;
                    if (bit_end)
                    begin
                        state   <= mcu_periph_pkg::data;
                        tx      <= shift[0];
                        bit_cnt <= divider;
                        bit_idx <= '0;
                    end
                end
                mcu_periph_pkg::data:
                begin
                    bit_cnt <= bit_cnt - 16'd1;
                    if (bit_end)
                    begin
                        bit_cnt <= divider;
                        bit_idx <= bit_idx + 3'd1;
                        if (bit_idx == 3'd7)
                        begin
                            state <= mcu_periph_pkg::stop;
                            tx    <= 1'b1;
                        end
                        else
                            tx <= shift[0];
                    end
                end
                default:
                begin
                    bit_cnt <= bit_cnt - 16'd1;
                    if (bit_end)
                    begin
                        state    <= mcu_periph_pkg::idle;
                        uart_irq <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb
    begin
        data_out = '0;
        if (sel)
        begin
            case (reg_idx)
                2'd0: data_out = tx_data;
                2'd1: data_out = {7'b0, busy};
                2'd2: data_out = divider[7:0];
                default: data_out = divider[15:8];
            endcase
        end
    end

    a_idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        state == mcu_periph_pkg::idle |-> tx);

endmodule

// File: src/mcu_timer.sv
// ================================================
// prescaled reloading down-counter with sticky
// wrap flag and interrupt pulse
// ================================================
`timescale 1ns/100ps

module mcu_timer (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sel,
    input  logic       write_en,
    input  logic [1:0] reg_idx,
    input  logic [7:0] data_in,
    output logic [7:0] data_out,
    output logic       timer_irq
);

    logic [7:0] prescale;
    logic [7:0] reload;
    logic [7:0] pre_cnt;
    logic [7:0] count;
    logic       run;
    logic       run_next;
    logic       wrapped;
    logic       ctrl_wr;
    logic       tick;
    logic       wrap;

    assign ctrl_wr  = sel && write_en && (reg_idx == 2'd2);
    // a write stopping the timer also blocks a wrap on that edge
    assign run_next = ctrl_wr ? data_in[0] : run;
    assign tick     = run && run_next && (pre_cnt == 8'd0);
    assign wrap     = tick && (count == 8'd0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            prescale  <= '0;
            reload    <= '0;
            pre_cnt   <= '0;
            count     <= '0;
            run       <= 1'b0;
            wrapped   <= 1'b0;
            timer_irq <= 1'b0;
        end
        else
        begin
            timer_irq <= wrap;
            run       <= run_next;
            if (sel && write_en && reg_idx == 2'd0)
                prescale <= data_in;
            if (sel && write_en && reg_idx == 2'd1)
                reload <= data_in;

            if (!run)
            begin
                pre_cnt <= prescale;
                count   <= reload;
            end
            else if (tick)
            begin
                pre_cnt <= prescale;
                count   <= wrap ? reload : count - 8'd1;
            end
            else
                pre_cnt <= pre_cnt - 8'd1;

            // set beats clear
            if (wrap)
                wrapped <= 1'b1;
            else if (ctrl_wr && data_in[1])
                wrapped <= 1'b0;
        end
    end

    always_comb
    begin
        data_out = '0;
        if (sel)
        begin
            case (reg_idx)
                2'd0: data_out = prescale;
                2'd1: data_out = reload;
                2'd2: data_out = {6'b0, wrapped, run};
                default: data_out = '0;
            endcase
        end
    end

    a_irq_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
        timer_irq |-> run && $past(run));

endmodule

// File: src/mcu_gpio.sv
// ================================================
// 16-bit gpio with input sampling, output bytes
// and an input-change interrupt
// ================================================
`timescale 1ns/100ps

module mcu_gpio (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sel,
    input  logic        write_en,
    input  logic [1:0]  reg_idx,
    input  logic [7:0]  data_in,
    output logic [7:0]  data_out,
    input  logic [15:0] gpi,
    output logic [15:0] gpo,
    output logic        gpio_irq
);

    logic [15:0] gpi_q;
    logic [15:0] gpi_last;

    // registered input and its previous sample
    always_ff @(posedge clk)
    begin
        gpi_q    <= gpi;
        gpi_last <= gpi_q;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gpo      <= '0;
            gpio_irq <= 1'b0;
        end
        else
        begin
            gpio_irq <= (gpi_q != gpi_last);
            if (sel && write_en)
            begin
                if (reg_idx == 2'd2)
                    gpo[7:0] <= data_in;
                else if (reg_idx == 2'd3)
                    gpo[15:8] <= data_in;
            end
        end
    end

    always_comb
    begin
        data_out = '0;
        if (sel)
        begin
            case (reg_idx)
                2'd0: data_out = gpi_q[7:0];
                2'd1: data_out = gpi_q[15:8];
                2'd2: data_out = gpo[7:0];
                default: data_out = gpo[15:8];
            endcase
        end
    end

endmodule

// File: src/mcu_periph_pkg.sv
// ================================================
// memory map, register counts, id byte and the
// enums shared by the peripheral units
// ================================================
package mcu_periph_pkg;

    localparam int offset_width = 4;

    // unit start offsets inside the window
    localparam logic [offset_width-1:0] hwi_off   = 4'd0;
    localparam logic [offset_width-1:0] intc_off  = 4'd1;
    localparam logic [offset_width-1:0] gpio_off  = 4'd3;
    localparam logic [offset_width-1:0] timer_off = 4'd7;
    localparam logic [offset_width-1:0] uart_off  = 4'd10;

    // register counts
    localparam logic [offset_width-1:0] hwi_size   = 4'd1;
    localparam logic [offset_width-1:0] intc_size  = 4'd2;
    localparam logic [offset_width-1:0] gpio_size  = 4'd4;
    localparam logic [offset_width-1:0] timer_size = 4'd3;
    localparam logic [offset_width-1:0] uart_size  = 4'd4;

    localparam logic [offset_width-1:0] total_size = 4'd14;

    localparam logic [7:0] hw_id = 8'hA5;

    typedef enum logic [1:0] {
        idle  = 2'd0,
        start = 2'd1,
        data  = 2'd2,
        stop  = 2'd3
    } uart_state_t;

    // bit positions in pending, mask and the request vector
    typedef enum logic [1:0] {
        gpio  = 2'd0,
        timer = 2'd1,
        uart  = 2'd2
    } irq_src_t;

endpackage
